//--- src/rvv_rt_pkg.sv
package rvv_rt_pkg;

    //////////////////////////////////////////////////
    // Sizes
    //////////////////////////////////////////////////
    localparam int NUM_RT_UOP = 4;           // Retire slots with slot 0 the oldest
    localparam int VLEN       = 128;         // Vector register bits
    localparam int VLENB      = VLEN / 8;    // Vector register bytes
    localparam int XLEN       = 32;          // Scalar register bits
    localparam int REG_IDX_W  = 5;
    localparam int VXSAT_W    = 1;

    //////////////////////////////////////////////////
    // Element byte classes
    //////////////////////////////////////////////////
    // Only BODY_ACTIVE bytes are written back
    typedef enum logic [1:0] {
        BODY_INACTIVE = 2'b00,
        TAIL          = 2'b01,
        PROLOGUE      = 2'b10,
        BODY_ACTIVE   = 2'b11
    } byte_type_t;

    // Vector config restored on a trap
    typedef struct packed {
        logic [6:0] vstart;
        logic [7:0] vl;
        logic [7:0] vtype;
        logic [1:0] vxrm;
    } vcsr_state_t;

    //////////////////////////////////////////////////
    // Retire payloads
    //////////////////////////////////////////////////
    typedef struct packed {
        logic                          w_type;      // 0 VRF, 1 XRF
        logic                          w_valid;
        logic                          trap_flag;
        logic [REG_IDX_W-1:0]          w_index;
        logic [VLEN-1:0]               w_data;
        byte_type_t [VLENB-1:0]        vd_type;
        logic [VLENB-1:0]              vxsaturate;  // Per byte saturation
        vcsr_state_t                   vector_csr;
    } rob_uop_t;

    typedef struct packed {
        logic [REG_IDX_W-1:0] rt_index;
        logic [VLEN-1:0]      rt_data;
        logic [VLENB-1:0]     rt_strobe;
    } vrf_write_t;

    typedef struct packed {
        logic [REG_IDX_W-1:0] rt_index;
        logic [XLEN-1:0]      rt_data;
    } xrf_write_t;

    // Decode to WAW hand-off for one slot
    typedef struct packed {
        logic                 cand;        // ROB valid and VRF type
        logic                 live_write;  // Also survives the trap check
        logic [REG_IDX_W-1:0] rt_index;
        logic [VLEN-1:0]      rt_data;
        logic [VLENB-1:0]     raw_strobe;  // Body-active bytes before WAW
    } vrf_cand_t;

endpackage

//--- src/rvv_rt_trap_chain.sv
`timescale 1ns/1ps

module rvv_rt_trap_chain (
    input  logic [rvv_rt_pkg::NUM_RT_UOP-1:0]                   rob_valid,
    input  rvv_rt_pkg::rob_uop_t [rvv_rt_pkg::NUM_RT_UOP-1:0]   rob_uop,
    output logic [rvv_rt_pkg::NUM_RT_UOP-1:0]                   live,
    output logic                                                vcsr_valid,
    output rvv_rt_pkg::vcsr_state_t                             vcsr_data
);

    // Bit i set when some slot older than i traps
    logic [rvv_rt_pkg::NUM_RT_UOP-1:0] older_trap;

    //////////////////////////////////////////////////
    // Trap shadow
    //////////////////////////////////////////////////
    assign older_trap[0] = 1'b0;   // Nothing is older than slot 0

    for (genvar i = 1; i < rvv_rt_pkg::NUM_RT_UOP; i++) begin : g_chain
        assign older_trap[i] = older_trap[i-1] | rob_uop[i-1].trap_flag;
    end

    for (genvar i = 0; i < rvv_rt_pkg::NUM_RT_UOP; i++) begin : g_live
        assign live[i] = rob_valid[i] & rob_uop[i].w_valid & ~older_trap[i];
    end

    //////////////////////////////////////////////////
    // VCSR restore
    //////////////////////////////////////////////////
    // Only the oldest slot may trap in a given cycle
    assign vcsr_valid = rob_valid[0] & rob_uop[0].w_valid & rob_uop[0].trap_flag;
    assign vcsr_data  = rob_uop[0].vector_csr;

    // The ROB only ever places a trap in slot 0
    for (genvar i = 1; i < rvv_rt_pkg::NUM_RT_UOP; i++) begin : g_chk_trap
        a_trap_slot0_only: assert final (!(rob_valid[i] && rob_uop[i].trap_flag))
            else $error("trap flag on retire slot %0d", i);
    end

endmodule

//--- src/rvv_rt_uop_decode.sv
`timescale 1ns/1ps

module rvv_rt_uop_decode (
    input  logic                    valid,     // ROB valid for this slot
    input  logic                    live,      // Valid, w_valid, no older trap
    input  rvv_rt_pkg::rob_uop_t    uop,
    output rvv_rt_pkg::vrf_cand_t   vrf_cand,
    output logic                    xrf_valid,
    output rvv_rt_pkg::xrf_write_t  xrf_data,
    output logic                    sat_hit
);

    logic [rvv_rt_pkg::VLENB-1:0] raw_strobe;
    logic [rvv_rt_pkg::VLENB-1:0] sat_bytes;

    //////////////////////////////////////////////////
    // Byte strobe from element classes
    //////////////////////////////////////////////////
    always_comb begin
        for (int b = 0; b < rvv_rt_pkg::VLENB; b++) begin
            raw_strobe[b] = (uop.vd_type[b] == rvv_rt_pkg::BODY_ACTIVE);
        end
    end

    // Saturation only counts on bytes that are really written
    assign sat_bytes = raw_strobe & uop.vxsaturate;
    assign sat_hit   = live & (|sat_bytes);

    //////////////////////////////////////////////////
    // VRF candidate
    //////////////////////////////////////////////////
    assign vrf_cand.cand       = valid & ~uop.w_type;  // Still takes part in WAW
    assign vrf_cand.live_write = live & ~uop.w_type;
    assign vrf_cand.rt_index   = uop.w_index;
    assign vrf_cand.rt_data    = uop.w_data;
    assign vrf_cand.raw_strobe = raw_strobe;

    // XRF write keeps the low scalar bits only
    assign xrf_valid         = live & uop.w_type;
    assign xrf_data.rt_index = uop.w_index;
    assign xrf_data.rt_data  = uop.w_data[rvv_rt_pkg::XLEN-1:0];

    // Trap chain must never mark an empty slot live
    a_live_needs_valid: assert final (!live || valid)
        else $error("live slot without ROB valid");

endmodule

//--- src/rvv_rt_waw_strobe.sv
`timescale 1ns/1ps

module rvv_rt_waw_strobe (
    input  rvv_rt_pkg::vrf_cand_t  [rvv_rt_pkg::NUM_RT_UOP-1:0]  vrf_cand,
    output logic [rvv_rt_pkg::NUM_RT_UOP-1:0]                    vrf_valid,
    output rvv_rt_pkg::vrf_write_t [rvv_rt_pkg::NUM_RT_UOP-1:0]  vrf_data
);

    // Bytes of slot i that some younger slot overwrites
    logic [rvv_rt_pkg::NUM_RT_UOP-1:0][rvv_rt_pkg::VLENB-1:0] kill_strobe;
    logic [rvv_rt_pkg::NUM_RT_UOP-1:0][rvv_rt_pkg::VLENB-1:0] final_strobe;

    //////////////////////////////////////////////////
    // Younger-wins byte masking
    //////////////////////////////////////////////////
    always_comb begin
        for (int i = 0; i < rvv_rt_pkg::NUM_RT_UOP; i++) begin
            kill_strobe[i] = '0;
            // Scan every younger slot
            for (int j = i + 1; j < rvv_rt_pkg::NUM_RT_UOP; j++) begin
                if (vrf_cand[j].cand && (vrf_cand[j].rt_index == vrf_cand[i].rt_index)) begin
                    kill_strobe[i] = kill_strobe[i] | vrf_cand[j].raw_strobe;
                end
            end
        end
    end

    for (genvar i = 0; i < rvv_rt_pkg::NUM_RT_UOP; i++) begin : g_port
        // Non-candidates keep their raw strobe
        assign final_strobe[i] = vrf_cand[i].cand ?
                                 (vrf_cand[i].raw_strobe & ~kill_strobe[i]) :
                                 vrf_cand[i].raw_strobe;

        assign vrf_valid[i] = vrf_cand[i].live_write;
        assign vrf_data[i]  = '{rt_index:  vrf_cand[i].rt_index,
                                rt_data:   vrf_cand[i].rt_data,
                                rt_strobe: final_strobe[i]};
    end

    //////////////////////////////////////////////////
    // Checks
    //////////////////////////////////////////////////
    // Each VRF byte has one writer per cycle
    for (genvar i = 0; i < rvv_rt_pkg::NUM_RT_UOP - 1; i++) begin : g_chk_old
        for (genvar j = i + 1; j < rvv_rt_pkg::NUM_RT_UOP; j++) begin : g_chk_young
            a_single_writer: assert final (
                !(vrf_valid[i] && vrf_valid[j] &&
                  (vrf_data[i].rt_index == vrf_data[j].rt_index)) ||
                ((vrf_data[i].rt_strobe & vrf_data[j].rt_strobe) == '0))
                else $error("byte written by slots %0d and %0d", i, j);
        end
    end

endmodule

//--- src/rvv_rt_ready_gen.sv
`timescale 1ns/1ps

module rvv_rt_ready_gen (
    input  rvv_rt_pkg::rob_uop_t [rvv_rt_pkg::NUM_RT_UOP-1:0]  rob_uop,
    input  logic                                               trap0,     // Slot 0 trap with VCSR write
    input  logic [rvv_rt_pkg::NUM_RT_UOP-1:0]                  sat_hit,
    input  logic [rvv_rt_pkg::NUM_RT_UOP-1:0]                  xrf_ready,
    input  logic                                               vcsr_ready,
    input  logic                                               vxsat_ready,
    output logic                                               vxsat_valid,
    output logic [rvv_rt_pkg::VXSAT_W-1:0]                     vxsat_data,
    output logic [rvv_rt_pkg::NUM_RT_UOP-1:0]                  rob_ready
);

    logic any_sat;
    logic vxsat_ok;   // No vxsat update pending, or it is accepted

    //////////////////////////////////////////////////
    // vxsat write
    //////////////////////////////////////////////////
    assign any_sat     = |sat_hit;
    assign vxsat_valid = any_sat;
    assign vxsat_data  = rvv_rt_pkg::VXSAT_W'(any_sat);
    assign vxsat_ok    = ~any_sat | vxsat_ready;

    //////////////////////////////////////////////////
    // Per-slot ready to the ROB
    //////////////////////////////////////////////////
    for (genvar i = 0; i < rvv_rt_pkg::NUM_RT_UOP; i++) begin : g_ready
        if (i == 0) begin : g_oldest
            assign rob_ready[i] = trap0            ? vcsr_ready :
                                  rob_uop[i].w_type ? (xrf_ready[i] & vxsat_ok) :
                                                      vxsat_ok;
        end else begin : g_younger
            assign rob_ready[i] = rob_uop[i].w_type ? (xrf_ready[i] & vxsat_ok) : vxsat_ok;
        end
    end

    // Slots behind a trap are dead, so they cannot saturate
    a_no_sat_behind_trap: assert final (
        !trap0 || (sat_hit[rvv_rt_pkg::NUM_RT_UOP-1:1] == '0))
        else $error("saturation reported behind a slot 0 trap");

endmodule

//--- src/rvv_backend_retire.sv
`timescale 1ns/1ps

module rvv_backend_retire (
    // ROB side
    input  logic [rvv_rt_pkg::NUM_RT_UOP-1:0]                    rob_valid,
    input  rvv_rt_pkg::rob_uop_t   [rvv_rt_pkg::NUM_RT_UOP-1:0]  rob_uop,
    output logic [rvv_rt_pkg::NUM_RT_UOP-1:0]                    rob_ready,
    // XRF write ports
    output logic [rvv_rt_pkg::NUM_RT_UOP-1:0]                    xrf_valid,
    output rvv_rt_pkg::xrf_write_t [rvv_rt_pkg::NUM_RT_UOP-1:0]  xrf_data,
    input  logic [rvv_rt_pkg::NUM_RT_UOP-1:0]                    xrf_ready,
    // VRF write ports without back-pressure
    output logic [rvv_rt_pkg::NUM_RT_UOP-1:0]                    vrf_valid,
    output rvv_rt_pkg::vrf_write_t [rvv_rt_pkg::NUM_RT_UOP-1:0]  vrf_data,
    // VCSR restore
    output logic                                                 vcsr_valid,
    output rvv_rt_pkg::vcsr_state_t                              vcsr_data,
    input  logic                                                 vcsr_ready,
    // vxsat
    output logic                                                 vxsat_valid,
    output logic [rvv_rt_pkg::VXSAT_W-1:0]                       vxsat_data,
    input  logic                                                 vxsat_ready
);

    logic [rvv_rt_pkg::NUM_RT_UOP-1:0]                    live;
    logic [rvv_rt_pkg::NUM_RT_UOP-1:0]                    sat_hit;
    rvv_rt_pkg::vrf_cand_t [rvv_rt_pkg::NUM_RT_UOP-1:0]   vrf_cand;

    //////////////////////////////////////////////////
    // Trap shadow and VCSR
    //////////////////////////////////////////////////
    rvv_rt_trap_chain u_trap_chain (
        .rob_valid  (rob_valid),
        .rob_uop    (rob_uop),
        .live       (live),
        .vcsr_valid (vcsr_valid),
        .vcsr_data  (vcsr_data)
    );

    for (genvar i = 0; i < rvv_rt_pkg::NUM_RT_UOP; i++) begin : g_slot
        rvv_rt_uop_decode u_decode (
            .valid     (rob_valid[i]),
            .live      (live[i]),
            .uop       (rob_uop[i]),
            .vrf_cand  (vrf_cand[i]),
            .xrf_valid (xrf_valid[i]),
            .xrf_data  (xrf_data[i]),
            .sat_hit   (sat_hit[i])
        );
    end

    //////////////////////////////////////////////////
    // VRF ports and ROB ready
    //////////////////////////////////////////////////
    rvv_rt_waw_strobe u_waw_strobe (
        .vrf_cand  (vrf_cand),
        .vrf_valid (vrf_valid),
        .vrf_data  (vrf_data)
    );

    rvv_rt_ready_gen u_ready_gen (
        .rob_uop     (rob_uop),
        .trap0       (vcsr_valid),   // Same condition as the VCSR write
        .sat_hit     (sat_hit),
        .xrf_ready   (xrf_ready),
        .vcsr_ready  (vcsr_ready),
        .vxsat_ready (vxsat_ready),
        .vxsat_valid (vxsat_valid),
        .vxsat_data  (vxsat_data),
        .rob_ready   (rob_ready)
    );

endmodule

//--- bench/tb_rvv_backend_retire.sv
`timescale 1ns/1ps

module tb_rvv_backend_retire;

    localparam int N           = rvv_rt_pkg::NUM_RT_UOP;
    localparam int VLENB       = rvv_rt_pkg::VLENB;
    localparam int NUM_VEC     = 2000;
    localparam int CLK_HALF    = 2;                      // 4 ns period
    localparam int WATCHDOG_NS = NUM_VEC * 4 + 200;

    // Expected view of every DUT output
    typedef struct packed {
        logic [N-1:0]                     rob_ready;
        logic [N-1:0]                     xrf_valid;
        rvv_rt_pkg::xrf_write_t [N-1:0]   xrf_data;
        logic [N-1:0]                     vrf_valid;
        rvv_rt_pkg::vrf_write_t [N-1:0]   vrf_data;
        logic                             vcsr_valid;
        rvv_rt_pkg::vcsr_state_t          vcsr_data;
        logic                             vxsat_valid;
        logic [rvv_rt_pkg::VXSAT_W-1:0]   vxsat_data;
    } expect_t;

    logic clk = 1'b0;
    logic rst_n;

    logic [N-1:0]                     rob_valid;
    rvv_rt_pkg::rob_uop_t [N-1:0]     rob_uop;
    logic [N-1:0]                     rob_ready;
    logic [N-1:0]                     xrf_valid;
    rvv_rt_pkg::xrf_write_t [N-1:0]   xrf_data;
    logic [N-1:0]                     xrf_ready;
    logic [N-1:0]                     vrf_valid;
    rvv_rt_pkg::vrf_write_t [N-1:0]   vrf_data;
    logic                             vcsr_valid;
    rvv_rt_pkg::vcsr_state_t          vcsr_data;
    logic                             vcsr_ready;
    logic                             vxsat_valid;
    logic [rvv_rt_pkg::VXSAT_W-1:0]   vxsat_data;
    logic                             vxsat_ready;

    int error_count;
    int check_count;

    rvv_backend_retire DUT (.*);

    always #(CLK_HALF) clk = ~clk;

    //////////////////////////////////////////////////
    // Reference model
    //////////////////////////////////////////////////
    function automatic expect_t ref_model(
        input logic [N-1:0]                 v,
        input rvv_rt_pkg::rob_uop_t [N-1:0] u,
        input logic [N-1:0]                 xr,
        input logic                         vcr,
        input logic                         vxr
    );
        expect_t                 e;
        logic [N-1:0]            live;
        logic [N-1:0][VLENB-1:0] active;
        logic                    shadow;   // Some older slot traps
        logic                    sat;
        logic                    sat_ok;
        e      = '0;
        shadow = 1'b0;
        sat    = 1'b0;
        for (int i = 0; i < N; i++) begin
            live[i] = v[i] & u[i].w_valid & ~shadow;
            shadow  = shadow | u[i].trap_flag;
            for (int b = 0; b < VLENB; b++) begin
                active[i][b] = (u[i].vd_type[b] == rvv_rt_pkg::BODY_ACTIVE);
            end
            sat = sat | (live[i] & (|(active[i] & u[i].vxsaturate)));
        end
        for (int i = 0; i < N; i++) begin
            e.vrf_valid[i]          = live[i] & ~u[i].w_type;
            e.vrf_data[i].rt_index  = u[i].w_index;
            e.vrf_data[i].rt_data   = u[i].w_data;
            e.vrf_data[i].rt_strobe = active[i];
            // Younger VRF writers to the same register own their bytes
            if (v[i] && !u[i].w_type) begin
                for (int j = i + 1; j < N; j++) begin
                    if (v[j] && !u[j].w_type && (u[j].w_index == u[i].w_index)) begin
                        e.vrf_data[i].rt_strobe = e.vrf_data[i].rt_strobe & ~active[j];
                    end
                end
            end
            e.xrf_valid[i]         = live[i] & u[i].w_type;
            e.xrf_data[i].rt_index = u[i].w_index;
            e.xrf_data[i].rt_data  = u[i].w_data[rvv_rt_pkg::XLEN-1:0];
        end
        e.vcsr_valid  = v[0] & u[0].w_valid & u[0].trap_flag;
        e.vcsr_data   = u[0].vector_csr;
        e.vxsat_valid = sat;
        e.vxsat_data  = sat;
        sat_ok        = ~sat | vxr;
        for (int i = 0; i < N; i++) begin
            if (i == 0 && e.vcsr_valid) e.rob_ready[i] = vcr;
            else if (u[i].w_type)       e.rob_ready[i] = xr[i] & sat_ok;
            else                        e.rob_ready[i] = sat_ok;
        end
        return e;
    endfunction

    task automatic report_mismatch(input string name, input logic [159:0] exp_val,
                                   input logic [159:0] act_val);
        $display("MISMATCH time %0t: %s expected %0h actual %0h", $time, name, exp_val, act_val);
        error_count++;
    endtask

    //////////////////////////////////////////////////
    // Stimulus
    //////////////////////////////////////////////////
    // 0 single VRF, 1 same-index VRF burst, 2 XRF mix, 3 slot 0 trap, 4 random
    task automatic drive_vector(input int scenario);
        logic [N-1:0]                 v;
        rvv_rt_pkg::rob_uop_t [N-1:0] u;
        for (int i = 0; i < N; i++) begin
            u[i].w_type    = (scenario >= 2) ? 1'($urandom_range(0, 1)) : 1'b0;
            u[i].w_valid   = (scenario <= 1) ? 1'b1 : ($urandom_range(0, 7) != 0);
            u[i].trap_flag = (i == 0) &&
                             ((scenario == 3) || (scenario == 4 && $urandom_range(0, 7) == 0));
            u[i].w_index   = (scenario == 1) ? 5'($urandom_range(0, 1)) :
                                               5'($urandom_range(0, 3));
            u[i].w_data    = {$urandom, $urandom, $urandom, $urandom};
            for (int b = 0; b < VLENB; b++) begin
                u[i].vd_type[b] = rvv_rt_pkg::byte_type_t'($urandom_range(0, 3));
            end
            u[i].vxsaturate = ($urandom_range(0, 3) == 0) ? VLENB'($urandom & $urandom) : '0;
            u[i].vector_csr = 25'($urandom);
            v[i] = (scenario == 0) ? (i == 0) : ($urandom_range(0, 5) != 0);
        end
        rob_valid   = v;
        rob_uop     = u;
        xrf_ready   = N'($urandom);   // Back-pressure on every port
        vcsr_ready  = 1'($urandom);
        vxsat_ready = 1'($urandom);
    endtask

    initial begin
        void'($urandom(32'h14410356));
        error_count = 0;
        check_count = 0;
        rst_n       = 1'b0;
        rob_valid   = '0;
        rob_uop     = '0;
        xrf_ready   = '0;
        vcsr_ready  = 1'b0;
        vxsat_ready = 1'b0;
        repeat (2) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
        for (int n = 0; n < NUM_VEC; n++) begin
            drive_vector(n % 5);
            @(negedge clk);
        end
        $display("Retire run done, %0d vectors checked, %0d errors", check_count, error_count);
        if (error_count == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

    //////////////////////////////////////////////////
    // Compare and watchdog
    //////////////////////////////////////////////////
    always @(posedge clk) begin
        expect_t e;
        if (rst_n) begin
            e = ref_model(rob_valid, rob_uop, xrf_ready, vcsr_ready, vxsat_ready);
            check_count++;
            assert (rob_ready === e.rob_ready)
                else report_mismatch("rob_ready", e.rob_ready, rob_ready);
            assert (vrf_valid === e.vrf_valid)
                else report_mismatch("vrf_valid", e.vrf_valid, vrf_valid);
            assert (xrf_valid === e.xrf_valid)
                else report_mismatch("xrf_valid", e.xrf_valid, xrf_valid);
            assert (vcsr_valid === e.vcsr_valid)
                else report_mismatch("vcsr_valid", e.vcsr_valid, vcsr_valid);
            assert (vxsat_valid === e.vxsat_valid)
                else report_mismatch("vxsat_valid", e.vxsat_valid, vxsat_valid);
            assert (vxsat_data === e.vxsat_data)
                else report_mismatch("vxsat_data", e.vxsat_data, vxsat_data);
            if (e.vcsr_valid) begin
                assert (vcsr_data === e.vcsr_data)
                    else report_mismatch("vcsr_data", e.vcsr_data, vcsr_data);
            end
            // Payloads only matter while their valid is up
            for (int i = 0; i < N; i++) begin
                if (e.vrf_valid[i]) begin
                    assert (vrf_data[i] === e.vrf_data[i])
                        else report_mismatch($sformatf("vrf_data[%0d]", i),
                                             e.vrf_data[i], vrf_data[i]);
                end
                if (e.xrf_valid[i]) begin
                    assert (xrf_data[i] === e.xrf_data[i])
                        else report_mismatch($sformatf("xrf_data[%0d]", i),
                                             e.xrf_data[i], xrf_data[i]);
                end
            end
        end
    end

    initial begin
        #(WATCHDOG_NS);
        $display("Timeout, the run did not finish within %0d ns", WATCHDOG_NS);
        $display("TESTS FAILED");
        $finish;
    end

endmodule

//--- project.f
src/rvv_rt_pkg.sv
src/rvv_rt_trap_chain.sv
src/rvv_rt_uop_decode.sv
src/rvv_rt_waw_strobe.sv
src/rvv_rt_ready_gen.sv
src/rvv_backend_retire.sv
bench/tb_rvv_backend_retire.sv

//--- Bender.yml
package:
  name: rvv_backend_retire

sources:
  - src/rvv_rt_pkg.sv
  - src/rvv_rt_trap_chain.sv
  - src/rvv_rt_uop_decode.sv
  - src/rvv_rt_waw_strobe.sv
  - src/rvv_rt_ready_gen.sv
  - src/rvv_backend_retire.sv
  - target: test
    files:
      - bench/tb_rvv_backend_retire.sv
